//--- rtl/battle_pkg.sv
`default_nettype none

package battle_pkg;

	typedef logic [11:0] color_t; // 4 bits each, r g b

	localparam color_t col_black      = 12'h000;
	localparam color_t col_background = 12'h56d; // dark sea blue
	localparam color_t col_ship       = 12'h555; // grey hull
	localparam color_t col_hit        = 12'hfa0; // orange flame
	localparam color_t col_line       = 12'hf0f; // magenta grid
	localparam color_t col_cursor     = 12'hf00; // red pointer

	typedef enum logic [1:0]
	{
		cell_free     = 2'b00,
		cell_occ      = 2'b01,
		cell_hit      = 2'b10,
		cell_outbound = 2'b11 // pixel is off the board
	} cell_status_t;

	typedef logic [9:0] coord_t;
	typedef logic [3:0] cell_idx_t;

	typedef enum logic
	{
		cmd_place = 1'b0, // free -> occupied
		cmd_fire  = 1'b1  // occupied -> hit
	} cmd_op_t;

	// board geometry in pixels
	localparam int board_cells = 10;
	localparam int cell_w      = 64;
	localparam int cell_h      = 48;
	localparam int line_half   = 2;
	localparam int cursor_half = 5;

	// counter position to colour output, in clocks
	localparam int pipe_lat = 3;

endpackage

`default_nettype wire

//--- rtl/vga_timing.sv
`default_nettype none

module vga_timing #(
	parameter int h_active = 640,
	parameter int h_front  = 16,
	parameter int h_sync   = 96,
	parameter int h_back   = 48,
	parameter int v_active = 480,
	parameter int v_front  = 10,
	parameter int v_sync   = 2,
	parameter int v_back   = 33
)
(
	input  wire                clk_in,
	input  wire                arst_n,
	output battle_pkg::coord_t x,
	output battle_pkg::coord_t y,
	output logic               active,
	output logic               hs,
	output logic               vs
);

	localparam int h_total    = h_active + h_front + h_sync + h_back;
	localparam int v_total    = v_active + v_front + v_sync + v_back;
	localparam int hs_start   = h_active + h_front;
	localparam int hs_end     = hs_start + h_sync;
	localparam int vs_start   = v_active + v_front;
	localparam int vs_end     = vs_start + v_sync;

	logic line_end;
	logic frame_end;

	assign line_end  = (x == battle_pkg::coord_t'(h_total - 1));
	assign frame_end = (y == battle_pkg::coord_t'(v_total - 1));

	// pixel counter
	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
			x <= '0;
		else if (line_end)
			x <= '0;
		else
			x <= x + 1'b1;
	end

	// line counter, steps once per line
	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
			y <= '0;
		else if (line_end)
		begin
			if (frame_end)
				y <= '0;
			else
				y <= y + 1'b1;
		end
	end

	// decoded straight from the counters
	assign active = (x < h_active) && (y < v_active);
	assign hs     = !((x >= hs_start) && (x < hs_end)); // negative polarity
	assign vs     = !((y >= vs_start) && (y < vs_end));

endmodule

`default_nettype wire

//--- rtl/pos_to_quadrant.sv
`default_nettype none

module pos_to_quadrant
(
	input  wire                   clk_in,
	input  wire                   arst_n,
	input  wire battle_pkg::coord_t x,
	input  wire battle_pkg::coord_t y,
	output battle_pkg::cell_idx_t cell_col,
	output battle_pkg::cell_idx_t cell_row,
	output logic                  outbound
);

	battle_pkg::cell_idx_t col_next;
	battle_pkg::cell_idx_t row_next;
	logic                  out_next;

	// highest pitch multiple not above the position, no divider needed
	always_comb
	begin
		col_next = '0;
		row_next = '0;
		for (int k = 1; k < battle_pkg::board_cells; k++)
		begin
			if (x >= k * battle_pkg::cell_w)
				col_next = battle_pkg::cell_idx_t'(k);
			if (y >= k * battle_pkg::cell_h)
				row_next = battle_pkg::cell_idx_t'(k);
		end
		out_next = (x >= battle_pkg::board_cells * battle_pkg::cell_w) ||
			(y >= battle_pkg::board_cells * battle_pkg::cell_h); // index would hit 10
	end

	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cell_col <= '0;
			cell_row <= '0;
			outbound <= 1'b1;
		end
		else
		begin
			cell_col <= col_next;
			cell_row <= row_next;
			outbound <= out_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/board_store.sv
`default_nettype none

module board_store #(
	parameter int cmd_depth = 4
)
(
	input  wire                          clk_in,
	input  wire                          arst_n,
	input  wire                          cmd_valid,
	input  wire battle_pkg::cmd_op_t     cmd_op,
	input  wire battle_pkg::cell_idx_t   cmd_col,
	input  wire battle_pkg::cell_idx_t   cmd_row,
	output logic                         cmd_credit,
	input  wire                          active,
	input  wire battle_pkg::cell_idx_t   cell_col,
	input  wire battle_pkg::cell_idx_t   cell_row,
	input  wire                          outbound,
	output battle_pkg::cell_status_t     status
);

	localparam int ptr_w = $clog2(cmd_depth);

	battle_pkg::cell_status_t cells [battle_pkg::board_cells][battle_pkg::board_cells];

	// command queue payload
	battle_pkg::cmd_op_t   q_op  [cmd_depth];
	battle_pkg::cell_idx_t q_col [cmd_depth];
	battle_pkg::cell_idx_t q_row [cmd_depth];

	logic [ptr_w:0]   wr_ptr; // extra bit tells full from empty
	logic [ptr_w:0]   rd_ptr;
	logic             empty;
	logic             full;
	logic             retire;
	logic [ptr_w-1:0] rd_idx;

	assign empty  = (wr_ptr == rd_ptr);
	assign full   = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
		(wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
	assign retire = !active && !empty; // only touch the board in blanking
	assign rd_idx = rd_ptr[ptr_w-1:0];

	always_ff @(posedge clk_in)
	begin
		if (cmd_valid && !full)
		begin
			q_op[wr_ptr[ptr_w-1:0]]  <= cmd_op;
			q_col[wr_ptr[ptr_w-1:0]] <= cmd_col;
			q_row[wr_ptr[ptr_w-1:0]] <= cmd_row;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
			wr_ptr <= '0;
		else if (cmd_valid && !full)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// retire one entry per blanking cycle, credit goes back with it
	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int r = 0; r < battle_pkg::board_cells; r++)
				for (int c = 0; c < battle_pkg::board_cells; c++)
					cells[r][c] <= battle_pkg::cell_free;
			rd_ptr     <= '0;
			cmd_credit <= 1'b0;
		end
		else
		begin
			cmd_credit <= retire;
			if (retire)
			begin
				rd_ptr <= rd_ptr + 1'b1;
				if ((q_col[rd_idx] < battle_pkg::board_cells) &&
					(q_row[rd_idx] < battle_pkg::board_cells)) // off-board commands are dropped
				begin
					if (q_op[rd_idx] == battle_pkg::cmd_place &&
						cells[q_row[rd_idx]][q_col[rd_idx]] == battle_pkg::cell_free)
						cells[q_row[rd_idx]][q_col[rd_idx]] <= battle_pkg::cell_occ;
					else if (q_op[rd_idx] == battle_pkg::cmd_fire &&
						cells[q_row[rd_idx]][q_col[rd_idx]] == battle_pkg::cell_occ)
						cells[q_row[rd_idx]][q_col[rd_idx]] <= battle_pkg::cell_hit;
				end
			end
		end
	end

	// read port for the renderer
	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
			status <= battle_pkg::cell_free;
		else if (outbound)
			status <= battle_pkg::cell_outbound;
		else
			status <= cells[cell_row][cell_col];
	end

endmodule

`default_nettype wire

//--- rtl/vga_driver.sv
`default_nettype none

module vga_driver
(
	input  wire                           clk_in,
	input  wire                           arst_n,
	input  wire                           enable,
	input  wire battle_pkg::coord_t       x,
	input  wire battle_pkg::coord_t       y,
	input  wire battle_pkg::coord_t       mouse_x,
	input  wire battle_pkg::coord_t       mouse_y,
	input  wire battle_pkg::cell_status_t status,
	output battle_pkg::color_t            color
);

	battle_pkg::color_t color_next;
	logic               on_hline;
	logic               on_vline;
	logic               on_cursor;

	// grid lines sit in (k*pitch - half, k*pitch + half]
	always_comb
	begin
		on_hline = 1'b0;
		on_vline = 1'b0;
		for (int k = 1; k < battle_pkg::board_cells; k++)
		begin
			if ((y > k * battle_pkg::cell_h - battle_pkg::line_half) &&
				(y <= k * battle_pkg::cell_h + battle_pkg::line_half))
				on_hline = 1'b1;
			if ((x > k * battle_pkg::cell_w - battle_pkg::line_half) &&
				(x <= k * battle_pkg::cell_w + battle_pkg::line_half))
				on_vline = 1'b1;
		end
	end

	// 32-bit sums, so no wrap near zero or the top of the range
	assign on_cursor = (x + battle_pkg::cursor_half >= mouse_x) &&
		(x <= mouse_x + battle_pkg::cursor_half) &&
		(y + battle_pkg::cursor_half >= mouse_y) &&
		(y <= mouse_y + battle_pkg::cursor_half);

	// later layers win
	always_comb
	begin
		color_next = battle_pkg::col_black;
		if (enable)
		begin
			case (status)
				battle_pkg::cell_occ: color_next = battle_pkg::col_ship;
				battle_pkg::cell_hit: color_next = battle_pkg::col_hit;
				default:              color_next = battle_pkg::col_background; // free, outbound
			endcase
			if (on_hline)
				color_next = battle_pkg::col_line;
			if (on_vline)
				color_next = battle_pkg::col_line;
			if (on_cursor)
				color_next = battle_pkg::col_cursor;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
			color <= battle_pkg::col_black;
		else
			color <= color_next;
	end

endmodule

`default_nettype wire

//--- rtl/battle_display.sv
`default_nettype none

module battle_display #(
	parameter int cmd_depth = 4,
	parameter int h_active  = 640,
	parameter int h_front   = 16,
	parameter int h_sync    = 96,
	parameter int h_back    = 48,
	parameter int v_active  = 480,
	parameter int v_front   = 10,
	parameter int v_sync    = 2,
	parameter int v_back    = 33
)
(
	input  wire                        clk_in,
	input  wire                        arst_n,
	input  wire battle_pkg::coord_t    mouse_x,
	input  wire battle_pkg::coord_t    mouse_y,
	input  wire                        cmd_valid,
	input  wire battle_pkg::cmd_op_t   cmd_op,
	input  wire battle_pkg::cell_idx_t cmd_col,
	input  wire battle_pkg::cell_idx_t cmd_row,
	output logic                       cmd_credit,
	output logic                       hsync,
	output logic                       vsync,
	output battle_pkg::color_t         color
);

	battle_pkg::coord_t       x;
	battle_pkg::coord_t       y;
	logic                     active;
	logic                     hs;
	logic                     vs;
	battle_pkg::cell_idx_t    cell_col;
	battle_pkg::cell_idx_t    cell_row;
	logic                     outbound;
	battle_pkg::cell_status_t status;

	battle_pkg::coord_t          x_d [2]; // lines up with status
	battle_pkg::coord_t          y_d [2];
	logic [1:0]                  active_d;
	logic [battle_pkg::pipe_lat-1:0] hs_d; // matches the colour path
	logic [battle_pkg::pipe_lat-1:0] vs_d;

	vga_timing #(
		.h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) vga_timing_i (
		.clk_in(clk_in), .arst_n(arst_n),
		.x(x), .y(y), .active(active), .hs(hs), .vs(vs)
	);

	pos_to_quadrant pos_to_quadrant_i (
		.clk_in(clk_in), .arst_n(arst_n), .x(x), .y(y),
		.cell_col(cell_col), .cell_row(cell_row), .outbound(outbound)
	);

	board_store #(.cmd_depth(cmd_depth)) board_store_i (
		.clk_in(clk_in), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_col(cmd_col), .cmd_row(cmd_row),
		.cmd_credit(cmd_credit), .active(active),
		.cell_col(cell_col), .cell_row(cell_row), .outbound(outbound), .status(status)
	);

	vga_driver vga_driver_i (
		.clk_in(clk_in), .arst_n(arst_n), .enable(active_d[1]),
		.x(x_d[1]), .y(y_d[1]), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.status(status), .color(color)
	);

	always_ff @(posedge clk_in)
	begin
		x_d[0] <= x;
		x_d[1] <= x_d[0];
		y_d[0] <= y;
		y_d[1] <= y_d[0];
	end

	// syncs idle high out of reset
	always_ff @(posedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
		begin
			active_d <= '0;
			hs_d     <= '1;
			vs_d     <= '1;
		end
		else
		begin
			active_d <= {active_d[0], active};
			hs_d     <= {hs_d[battle_pkg::pipe_lat-2:0], hs};
			vs_d     <= {vs_d[battle_pkg::pipe_lat-2:0], vs};
		end
	end

	assign hsync = hs_d[battle_pkg::pipe_lat-1];
	assign vsync = vs_d[battle_pkg::pipe_lat-1];

endmodule

`default_nettype wire

//--- bench/battle_display_tests.svh
// sends one command against a credit and applies the place and fire rules to the model
task automatic send_cmd(battle_pkg::cmd_op_t op, int col, int row);
	int waited;
	waited = 0;
	while (credits == 0 && waited < 2 * h_total)
	begin
		@(posedge clk_in);
		#2;
		waited++;
	end
	if (credits == 0)
	begin
		errors++;
		$display("protocol fault at %0t: no credit left for a command, not sent", $time);
		return;
	end
	cmd_valid = 1'b1;
	cmd_op    = op;
	cmd_col   = battle_pkg::cell_idx_t'(col);
	cmd_row   = battle_pkg::cell_idx_t'(row);
	credits--;
	if (col < 10 && row < 10)
	begin
		if (op == battle_pkg::cmd_place && model[row][col] == battle_pkg::cell_free)
			model[row][col] = battle_pkg::cell_occ;
		else if (op == battle_pkg::cmd_fire && model[row][col] == battle_pkg::cell_occ)
			model[row][col] = battle_pkg::cell_hit;
	end
	@(posedge clk_in);
	#2;
	cmd_valid = 1'b0;
endtask

task automatic drain();
	int waited;
	waited = 0;
	while (credits < cmd_depth && waited < 2 * h_total) // one blanking is enough
	begin
		@(posedge clk_in);
		#2;
		waited++;
	end
	if (credits < cmd_depth)
	begin
		errors++;
		$display("timeout at %0t: only %0d of %0d credits came back", $time, credits, cmd_depth);
	end
endtask

// lets the pipeline settle and then compares one whole frame
task automatic check_frame();
	repeat (battle_pkg::pipe_lat + 1) @(posedge clk_in);
	#2;
	check_left = h_total * v_total;
	wait (check_left == 0);
	@(posedge clk_in);
	#2;
endtask

task automatic wait_pixel(int x, int y);
	do
	begin
		@(posedge clk_in);
		#2;
	end
	while (px != x || py != y);
endtask

task automatic test_reset();
	repeat (16)
	begin
		@(negedge clk_in);
		check_color(-1, -1, battle_pkg::col_black, color);
		check_sync("hsync", 1'b1, hsync);
		check_sync("vsync", 1'b1, vsync);
	end
	@(posedge clk_in);
	#2;
	arst_n = 1'b1;
	@(negedge clk_in);
	check_color(-1, -1, battle_pkg::col_black, color);
	check_sync("hsync", 1'b1, hsync);
	check_sync("vsync", 1'b1, vsync);
	check_frame();
endtask

task automatic test_place();
	int col;
	int row;
	for (int i = 0; i < 8; i++)
	begin
		do
		begin
			col = next_random(4) % 10;
			row = next_random(4) % 10;
		end
		while (model[row][col] != battle_pkg::cell_free);
		send_cmd(battle_pkg::cmd_place, col, row);
	end
	drain();
	check_frame();
endtask

task automatic test_fire();
	int targets [$]; // row * 10 + col
	int pick;
	for (int i = 0; i < 100 && targets.size() < 2; i++)
		if (model[i / 10][i % 10] == battle_pkg::cell_occ)
			targets.push_back(i);
	while (targets.size() < 4)
	begin
		pick = next_random(7) % 100;
		if (model[pick / 10][pick % 10] == battle_pkg::cell_free &&
			(targets.size() < 3 || targets[2] != pick))
			targets.push_back(pick);
	end
	foreach (targets[i])
		send_cmd(battle_pkg::cmd_fire, targets[i] % 10, targets[i] / 10);
	drain();
	send_cmd(battle_pkg::cmd_fire, targets[0] % 10, targets[0] / 10); // already hit
	drain();
	check_frame();
endtask

task automatic test_cursor();
	mouse_x = battle_pkg::coord_t'(next_random(10) % h_active);
	mouse_y = battle_pkg::coord_t'(next_random(9) % v_active);
	check_frame();
	mouse_x = battle_pkg::coord_t'(3 * battle_pkg::cell_w); // on a grid crossing
	mouse_y = battle_pkg::coord_t'(4 * battle_pkg::cell_h);
	check_frame();
	mouse_x = 10'd1000;
	mouse_y = 10'd1000;
endtask

task automatic test_credits();
	int base;
	int col;
	int row;
	wait_pixel(0, 100); // start of an active line
	base = credit_pulses;
	for (int i = 0; i < cmd_depth; i++)
	begin
		col = next_random(4) % 10;
		row = next_random(4) % 10;
		send_cmd(battle_pkg::cmd_place, col, row);
	end
	wait_pixel(h_active - battle_pkg::pipe_lat, 100); // counter just left active video
	check_status_credit("cmd_credit during active video", 0, credit_pulses - base);
	wait_pixel(h_total - 1, 100);
	check_status_credit("cmd_credit by end of blanking", cmd_depth, credit_pulses - base);
	col = next_random(4) % 10;
	row = next_random(4) % 10;
	send_cmd(battle_pkg::cmd_place, col, row);
	drain();
	check_frame();
endtask

task automatic test_out_of_range();
	int base;
	base = credit_pulses;
	send_cmd(battle_pkg::cmd_place, 12, 3);
	drain();
	check_status_credit("cmd_credit for column 12", 1, credit_pulses - base);
	check_frame();
endtask

//--- bench/battle_display_tb.sv
`default_nettype none

module battle_display_tb;

	localparam int cmd_depth    = 4;
	localparam int h_active     = 640;
	localparam int h_front      = 16;
	localparam int h_sync       = 96;
	localparam int h_back       = 48;
	localparam int v_active     = 480;
	localparam int v_front      = 10;
	localparam int v_sync       = 2;
	localparam int v_back       = 33;
	localparam int h_total      = h_active + h_front + h_sync + h_back;
	localparam int v_total      = v_active + v_front + v_sync + v_back;
	localparam int frame_checks = 7; // whole frames compared by the tests

	logic                     clk_in;
	logic                     arst_n;
	battle_pkg::coord_t       mouse_x;
	battle_pkg::coord_t       mouse_y;
	logic                     cmd_valid;
	battle_pkg::cmd_op_t      cmd_op;
	battle_pkg::cell_idx_t    cmd_col;
	battle_pkg::cell_idx_t    cmd_row;
	logic                     cmd_credit;
	logic                     hsync;
	logic                     vsync;
	battle_pkg::color_t       color;

	battle_pkg::cell_status_t model [10][10]; // expected board
	logic [15:0] lfsr          = 16'd38;
	int          credits       = cmd_depth; // held by the sender
	int          credit_pulses = 0;
	int          check_left    = 0; // pixels still to compare
	int          errors        = 0;
	int          checks        = 0;
	int          px            = 0; // displayed position
	int          py            = 0;
	logic        locked_h      = 1'b0;
	logic        locked_v      = 1'b0;
	logic        hs_prev       = 1'b1;
	logic        vs_prev       = 1'b1;

	initial
	begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;
	end

	battle_display #(
		.cmd_depth(cmd_depth),
		.h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) battle_display_i (
		.clk_in(clk_in), .arst_n(arst_n), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_col(cmd_col), .cmd_row(cmd_row),
		.cmd_credit(cmd_credit), .hsync(hsync), .vsync(vsync), .color(color)
	);

	// fibonacci taps at 16 14 13 11
	function automatic int next_random(int bits);
		int   value;
		logic fb;
		value = 0;
		for (int i = 0; i < bits; i++)
		begin
			fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr  = {lfsr[14:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	function automatic battle_pkg::color_t expect_color(int x, int y);
		battle_pkg::color_t c;
		if (x >= h_active || y >= v_active)
			return battle_pkg::col_black;
		case (model[y / battle_pkg::cell_h][x / battle_pkg::cell_w])
			battle_pkg::cell_occ: c = battle_pkg::col_ship;
			battle_pkg::cell_hit: c = battle_pkg::col_hit;
			default:              c = battle_pkg::col_background;
		endcase
		for (int k = 1; k < 10; k++)
			if ((y > 48 * k - 2 && y <= 48 * k + 2) || (x > 64 * k - 2 && x <= 64 * k + 2))
				c = battle_pkg::col_line;
		if (x - int'(mouse_x) <= 5 && int'(mouse_x) - x <= 5 &&
			y - int'(mouse_y) <= 5 && int'(mouse_y) - y <= 5) // 11x11 square
			c = battle_pkg::col_cursor;
		return c;
	endfunction

	task automatic check_color(int x, int y, battle_pkg::color_t expected,
		battle_pkg::color_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %0t color at %0d,%0d: expected %h, got %h",
				$time, x, y, expected, actual);
		end
	endtask

	task automatic check_sync(string name, logic expected, logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %0t %s: expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_status_credit(string name, int expected, int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("ERROR %0t %s: expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// credit counting and displayed pixel tracking sampled mid-cycle
	always @(negedge clk_in or negedge arst_n)
	begin
		if (!arst_n)
		begin
			locked_h = 1'b0;
			locked_v = 1'b0;
			hs_prev  = 1'b1;
			vs_prev  = 1'b1;
		end
		else
		begin
			if (cmd_credit)
			begin
				credits++;
				credit_pulses++;
				if (credits > cmd_depth)
				begin
					errors++;
					$display("credit returned at %0t with no command outstanding", $time);
				end
			end
			px++;
			if (px == h_total)
			begin
				px = 0;
				py = (py + 1) % v_total;
			end
			if (hs_prev && !hsync)
			begin
				px       = h_active + h_front; // sync starts after the front porch
				locked_h = 1'b1;
			end
			if (vs_prev && !vsync)
			begin
				py       = v_active + v_front;
				locked_v = 1'b1;
			end
			hs_prev = hsync;
			vs_prev = vsync;
			if (check_left > 0 && locked_h && locked_v)
			begin
				check_color(px, py, expect_color(px, py), color);
				check_sync("hsync",
					!(px >= h_active + h_front && px < h_active + h_front + h_sync), hsync);
				check_sync("vsync",
					!(py >= v_active + v_front && py < v_active + v_front + v_sync), vsync);
				check_left--;
			end
		end
	end

	`include "battle_display_tests.svh"

	// compared frames plus one to lock the tracker and some for line waits
	initial
	begin
		#(longint'(frame_checks + 4) * h_total * v_total * 40);
		$display("timeout: run did not end within %0d frames", frame_checks + 4);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		arst_n    = 1'b0;
		mouse_x   = 10'd1000; // cursor parked off screen
		mouse_y   = 10'd1000;
		cmd_valid = 1'b0;
		cmd_op    = battle_pkg::cmd_place;
		cmd_col   = '0;
		cmd_row   = '0;
		for (int r = 0; r < 10; r++)
			for (int c = 0; c < 10; c++)
				model[r][c] = battle_pkg::cell_free;
		test_reset();
		test_place();
		test_fire();
		test_cursor();
		test_credits();
		test_out_of_range();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- battle_display.f
+incdir+bench
rtl/battle_pkg.sv
rtl/vga_timing.sv
rtl/pos_to_quadrant.sv
rtl/board_store.sv
rtl/vga_driver.sv
rtl/battle_display.sv
bench/battle_display_tb.sv

//--- Makefile
# Verilator build of the battle board display testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f battle_display.f \
		--top-module battle_display_tb -Mdir obj_dir

run: compile
	./obj_dir/Vbattle_display_tb | tee run.log
	grep -q "^TESTS PASSED$$" run.log

clean:
	rm -rf obj_dir run.log
